// File: files.f
design/rv32i_pkg.sv
design/fetch_unit.sv
design/regfile.sv
design/control_rom.sv
design/hazard_unit.sv
design/instruction_decode.sv
design/execute_stage.sv
design/rv32i_core.sv
verification/core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - design/rv32i_pkg.sv
  - design/fetch_unit.sv
  - design/regfile.sv
  - design/control_rom.sv
  - design/hazard_unit.sv
  - design/instruction_decode.sv
  - design/execute_stage.sv
  - design/rv32i_core.sv
  - target: test
    files:
      - verification/core_tb.sv

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    logic                 clk;
    logic                 rst;
    rv32i_pkg::rv32i_word fetch_pc;
    rv32i_pkg::rv32i_word fetch_instr;
    logic                 retire_valid;
    rv32i_pkg::rv32i_word retire_pc;
    rv32i_pkg::rv32i_reg  retire_rd;
    rv32i_pkg::rv32i_word retire_value;

    logic [31:0] prog [64];
    logic [31:0] mregs [32];
    logic [31:0] lfsr_state = 32'h8fee8a79;
    logic [31:0] exp_pc [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_val [$];
    int          checked = 0;
    int          cycles = 0;
    int          limit = 0;

    rv32i_core uut
    (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc     (fetch_pc),
        .fetch_instr  (fetch_instr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // small register window keeps dependences frequent, x31 stays free
    function automatic logic [4:0] random_reg();
        return 5'(rand_bits(3));
    endfunction

    function automatic int forward_slot(input int i);
        int t;
        t = i + 1 + int'(rand_bits(2));
        if (t > 63)
            t = 63;
        // the lui/addi/jalr run in slots 8 to 10 is never skipped
        if (i < 8 && t > 8)
            t = 8;
        return t;
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic make_program();
        int          kind;
        logic [31:0] jalr_tgt;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        jalr_tgt = 4 * (12 + rand_bits(3));
        for (int i = 0; i < 64; i++)
        begin
            kind = int'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            rs1  = random_reg();
            rs2  = random_reg();
            alt  = rand_bits(1) == 32'd1;
            if (i == 8)
                prog[i] = u_format(20'h0, 5'd31, rv32i_pkg::op_lui);
            else if (i == 9)
                prog[i] = i_format(jalr_tgt[11:0], 5'd31, 3'b000, 5'd31, rv32i_pkg::op_imm);
            else if (i == 10)
                // odd offset checks that bit zero is cleared
                prog[i] = i_format(12'd1, 5'd31, 3'b000, random_reg(), rv32i_pkg::op_jalr);
            else if (i == 63)
                prog[i] = j_format(21'd0, 5'd0);
            else if (kind < 2)
            begin
                if (f3 == 3'b001)
                    imm = {7'b0, 5'(rand_bits(5))};
                else if (f3 == 3'b101)
                    imm = {1'b0, alt, 5'b0, 5'(rand_bits(5))};
                else
                    imm = 12'(rand_bits(12));
                prog[i] = i_format(imm, rs1, f3, random_reg(), rv32i_pkg::op_imm);
            end
            else if (kind < 4)
                prog[i] = r_format((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
                                   rs2, rs1, f3, random_reg(), rv32i_pkg::op_reg);
            else if (kind == 4)
                prog[i] = u_format(20'(rand_bits(20)), random_reg(),
                                   alt ? rv32i_pkg::op_lui : rv32i_pkg::op_auipc);
            else if (kind < 7)
            begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;
                // equal operands make eq/ge kinds taken
                if (alt)
                    rs2 = rs1;
                prog[i] = b_format(13'((forward_slot(i) - i) * 4), rs2, rs1, f3);
            end
            else
                prog[i] = j_format(21'((forward_slot(i) - i) * 4), random_reg());
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] pc);
        if (pc < 32'd256)
            return prog[pc[7:2]];
        return rv32i_pkg::nop_instr;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ISA reference for one instruction
    function automatic void rv_exec(input logic [31:0] instr, input logic [31:0] pc,
                                    input logic [31:0] regs [32],
                                    output logic [31:0] next_pc, output logic [4:0] rd,
                                    output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        a       = regs[instr[19:15]];
        b       = regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_u   = {instr[31:12], 12'h000};
        imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        f3      = instr[14:12];
        next_pc = pc + 32'd4;
        rd      = instr[11:7];
        value   = '0;
        case (instr[6:0])
            rv32i_pkg::op_lui:   value = imm_u;
            rv32i_pkg::op_auipc: value = pc + imm_u;
            rv32i_pkg::op_jal:
            begin
                value   = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            rv32i_pkg::op_jalr:
            begin
                value   = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            rv32i_pkg::op_br:
            begin
                rd = 5'd0;
                if (branch_cond(f3, a, b))
                    next_pc = pc + imm_b;
            end
            rv32i_pkg::op_imm:   value = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
            default:             value = alu_ref(f3, instr[30], a, b);
        endcase
    endfunction

    task automatic build_expected();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [4:0]  rd;
        logic [31:0] value;
        pc = rv32i_pkg::reset_pc;
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;
        for (int step = 0; step < 200; step++)
        begin
            rv_exec(fetch_word(pc), pc, mregs, npc, rd, value);
            exp_pc.push_back(pc);
            exp_rd.push_back({27'd0, rd});
            exp_val.push_back(value);
            if (rd != 5'd0)
                mregs[rd] = value;
            // self-loop reached
            if (pc == 32'd252)
                break;
            pc = npc;
        end
        if (exp_pc[$] != 32'd252)
        begin
            $display("reference model never reached the final self-loop");
            $display("*** TEST FAILED ***");
            $fatal(1, "bad program");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch");
        end
    endtask

    always @(negedge clk)
    begin
        fetch_instr = fetch_word(fetch_pc);
    end

    // retire checker and end of run
    always @(negedge clk)
    begin
        if (!rst)
        begin
            cycles = cycles + 1;
            if (retire_valid && checked >= exp_pc.size())
            begin
                $display("core retired more instructions than the reference model");
                $display("*** TEST FAILED ***");
                $fatal(1, "extra retire");
            end
            else
            begin
                if (retire_valid)
                begin
                    check_value($sformatf("retire %0d pc", checked), exp_pc[checked],
                                retire_pc);
                    check_value($sformatf("retire %0d rd", checked), exp_rd[checked],
                                {27'd0, retire_rd});
                    check_value($sformatf("retire %0d value", checked), exp_val[checked],
                                retire_value);
                    checked = checked + 1;
                end
                if (checked == exp_pc.size())
                begin
                    $display("*** TEST PASSED ***");
                    $finish;
                end
                else if (cycles >= limit)
                begin
                    $display("core stopped retiring after %0d of %0d instructions",
                             checked, exp_pc.size());
                    $display("*** TEST FAILED ***");
                    $fatal(1, "timeout");
                end
            end
        end
    end

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_instr = rv32i_pkg::nop_instr;
        make_program();
        build_expected();
        limit = 3 * exp_pc.size() + 50;
        repeat (5) @(negedge clk);
        check_value("reset fetch_pc", rv32i_pkg::reset_pc, fetch_pc);
        check_value("reset retire_valid", 32'd0, {31'd0, retire_valid});
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: design/rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core
(
    input  logic                 clk,
    input  logic                 rst,
    output rv32i_pkg::rv32i_word fetch_pc,
    input  rv32i_pkg::rv32i_word fetch_instr,
    output logic                 retire_valid,
    output rv32i_pkg::rv32i_word retire_pc,
    output rv32i_pkg::rv32i_reg  retire_rd,
    output rv32i_pkg::rv32i_word retire_value
);

    logic                 stall;
    logic                 br_taken;
    rv32i_pkg::rv32i_word br_target;
    logic                 wb_wen;
    rv32i_pkg::rv32i_reg  wb_rd;
    rv32i_pkg::rv32i_word wb_value;

    // ID/EX state
    logic                 ex_valid, ex_is_branch, ex_is_jump, ex_is_jalr, ex_wen;
    rv32i_pkg::rv32i_word ex_pc, ex_alu_a, ex_alu_b, ex_rs1, ex_rs2, ex_imm;
    rv32i_pkg::alu_ops_t  ex_alu_op;
    rv32i_pkg::cmp_ops_t  ex_cmp_op;
    rv32i_pkg::rv32i_reg  ex_rd;

    fetch_unit fetch_unit
    (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .br_taken  (br_taken),
        .br_target (br_target),
        .pc        (fetch_pc)
    );

    instruction_decode instruction_decode
    (
        .clk (clk), .rst (rst), .br_taken (br_taken),
        .pc (fetch_pc), .instr (fetch_instr),
        .wb_value (wb_value), .wb_rd (wb_rd), .wb_wen (wb_wen),
        .stall (stall),
        .ex_valid (ex_valid), .ex_pc (ex_pc),
        .ex_alu_a (ex_alu_a), .ex_alu_b (ex_alu_b),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
        .ex_alu_op (ex_alu_op), .ex_cmp_op (ex_cmp_op),
        .ex_is_branch (ex_is_branch), .ex_is_jump (ex_is_jump),
        .ex_is_jalr (ex_is_jalr),
        .ex_rd (ex_rd), .ex_wen (ex_wen), .ex_imm (ex_imm)
    );

    execute_stage execute_stage
    (
        .clk (clk), .rst (rst),
        .ex_valid (ex_valid), .ex_pc (ex_pc),
        .ex_alu_a (ex_alu_a), .ex_alu_b (ex_alu_b),
        .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
        .ex_alu_op (ex_alu_op), .ex_cmp_op (ex_cmp_op),
        .ex_is_branch (ex_is_branch), .ex_is_jump (ex_is_jump),
        .ex_is_jalr (ex_is_jalr),
        .ex_rd (ex_rd), .ex_wen (ex_wen), .ex_imm (ex_imm),
        .br_taken (br_taken), .br_target (br_target),
        .wb_wen (wb_wen), .wb_rd (wb_rd), .wb_value (wb_value),
        .retire_valid (retire_valid), .retire_pc (retire_pc),
        .retire_rd (retire_rd), .retire_value (retire_value)
    );

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  rv32i_pkg::rv32i_word ex_pc,
    input  rv32i_pkg::rv32i_word ex_alu_a,
    input  rv32i_pkg::rv32i_word ex_alu_b,
    input  rv32i_pkg::rv32i_word ex_rs1,
    input  rv32i_pkg::rv32i_word ex_rs2,
    input  rv32i_pkg::alu_ops_t  ex_alu_op,
    input  rv32i_pkg::cmp_ops_t  ex_cmp_op,
    input  logic                 ex_is_branch,
    input  logic                 ex_is_jump,
    input  logic                 ex_is_jalr,
    input  rv32i_pkg::rv32i_reg  ex_rd,
    input  logic                 ex_wen,
    input  rv32i_pkg::rv32i_word ex_imm,
    output logic                 br_taken,
    output rv32i_pkg::rv32i_word br_target,
    output logic                 wb_wen,
    output rv32i_pkg::rv32i_reg  wb_rd,
    output rv32i_pkg::rv32i_word wb_value,
    output logic                 retire_valid,
    output rv32i_pkg::rv32i_word retire_pc,
    output rv32i_pkg::rv32i_reg  retire_rd,
    output rv32i_pkg::rv32i_word retire_value
);

    rv32i_pkg::rv32i_word alu_out;
    rv32i_pkg::rv32i_word result;
    logic                 cmp_true;

    always_comb
    begin
        case (ex_alu_op)
            rv32i_pkg::alu_sub:    alu_out = ex_alu_a - ex_alu_b;
            rv32i_pkg::alu_sll:    alu_out = ex_alu_a << ex_alu_b[4:0];
            rv32i_pkg::alu_slt:    alu_out = {31'd0, $signed(ex_alu_a) < $signed(ex_alu_b)};
            rv32i_pkg::alu_sltu:   alu_out = {31'd0, ex_alu_a < ex_alu_b};
            rv32i_pkg::alu_xor:    alu_out = ex_alu_a ^ ex_alu_b;
            rv32i_pkg::alu_srl:    alu_out = ex_alu_a >> ex_alu_b[4:0];
            rv32i_pkg::alu_sra:    alu_out = $signed(ex_alu_a) >>> ex_alu_b[4:0];
            rv32i_pkg::alu_or:     alu_out = ex_alu_a | ex_alu_b;
            rv32i_pkg::alu_and:    alu_out = ex_alu_a & ex_alu_b;
            rv32i_pkg::alu_pass_b: alu_out = ex_alu_b;
            default:               alu_out = ex_alu_a + ex_alu_b;
        endcase

        case (ex_cmp_op)
            rv32i_pkg::beq:  cmp_true = ex_rs1 == ex_rs2;
            rv32i_pkg::bne:  cmp_true = ex_rs1 != ex_rs2;
            rv32i_pkg::blt:  cmp_true = $signed(ex_rs1) < $signed(ex_rs2);
            rv32i_pkg::bge:  cmp_true = $signed(ex_rs1) >= $signed(ex_rs2);
            rv32i_pkg::bltu: cmp_true = ex_rs1 < ex_rs2;
            default:         cmp_true = ex_rs1 >= ex_rs2;
        endcase
    end

    assign br_taken  = ex_valid && (ex_is_jump || (ex_is_branch && cmp_true));
    // jalr clears the low target bit
    assign br_target = !ex_is_jump ? ex_pc + ex_imm
                     : ex_is_jalr ? {alu_out[31:1], 1'b0} : alu_out;
    // jumps write the link address
    assign result    = ex_is_jump ? ex_pc + 32'd4 : alu_out;

    // EX/WB register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            retire_valid <= 1'b0;
            wb_wen       <= 1'b0;
        end
        else
        begin
            retire_valid <= ex_valid;
            wb_wen       <= ex_valid && ex_wen;
        end
        retire_pc    <= ex_pc;
        retire_rd    <= ex_is_branch ? 5'd0 : ex_rd;
        retire_value <= ex_is_branch ? '0 : result;
    end

    assign wb_rd    = retire_rd;
    assign wb_value = retire_value;

    // the redirecting instruction retires, the slot flushed behind it does not
    flushed_slot_never_retires: assert property (@(posedge clk) disable iff (rst)
        br_taken |=> retire_valid ##1 !retire_valid);

endmodule

`default_nettype wire

// File: design/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     br_taken,
    input  rv32i_pkg::rv32i_word     pc,
    input  rv32i_pkg::rv32i_word     instr,
    input  rv32i_pkg::rv32i_word     wb_value,
    input  rv32i_pkg::rv32i_reg      wb_rd,
    input  logic                     wb_wen,
    output logic                     stall,
    output logic                     ex_valid,
    output rv32i_pkg::rv32i_word     ex_pc,
    output rv32i_pkg::rv32i_word     ex_alu_a,
    output rv32i_pkg::rv32i_word     ex_alu_b,
    output rv32i_pkg::rv32i_word     ex_rs1,
    output rv32i_pkg::rv32i_word     ex_rs2,
    output rv32i_pkg::alu_ops_t      ex_alu_op,
    output rv32i_pkg::cmp_ops_t      ex_cmp_op,
    output logic                     ex_is_branch,
    output logic                     ex_is_jump,
    output logic                     ex_is_jalr,
    output rv32i_pkg::rv32i_reg      ex_rd,
    output logic                     ex_wen,
    output rv32i_pkg::rv32i_word     ex_imm
);

    rv32i_pkg::rv32i_word dec_instr;
    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word j_imm;
    rv32i_pkg::rv32i_word reg_a;
    rv32i_pkg::rv32i_word reg_b;
    rv32i_pkg::rv32i_word alu_a;
    rv32i_pkg::rv32i_word alu_b;

    rv32i_pkg::alu_ops_t     alu_op;
    rv32i_pkg::cmp_ops_t     cmp_op;
    rv32i_pkg::alumux1_sel_t alumux1_sel;
    rv32i_pkg::alumux2_sel_t alumux2_sel;
    logic is_branch, is_jump, is_jalr, wen, valid, uses_rs1, uses_rs2;

    // wrong-path slot decodes as a nop so it cannot raise a stall
    assign dec_instr = br_taken ? rv32i_pkg::nop_instr : instr;

    assign i_imm = {{21{dec_instr[31]}}, dec_instr[30:20]};
    assign u_imm = {dec_instr[31:12], 12'h000};
    assign b_imm = {{20{dec_instr[31]}}, dec_instr[7], dec_instr[30:25],
                    dec_instr[11:8], 1'b0};
    assign j_imm = {{12{dec_instr[31]}}, dec_instr[19:12], dec_instr[20],
                    dec_instr[30:21], 1'b0};

    regfile regfile
    (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_wen),
        .in    (wb_value),
        .src_a (dec_instr[19:15]),
        .src_b (dec_instr[24:20]),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    control_rom control_rom
    (
        .instr       (dec_instr),
        .alu_op      (alu_op),
        .cmp_op      (cmp_op),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .is_jalr     (is_jalr),
        .wen         (wen),
        .valid       (valid),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2)
    );

    hazard_unit hazard_unit
    (
        .src_a    (dec_instr[19:15]),
        .src_b    (dec_instr[24:20]),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .ex_rd    (ex_rd),
        .ex_wen   (ex_wen),
        .ex_valid (ex_valid),
        .bubble   (stall)
    );

    // operand muxes
    always_comb
    begin
        alu_a = (alumux1_sel == rv32i_pkg::pc_out) ? pc : reg_a;
        case (alumux2_sel)
            rv32i_pkg::i_imm: alu_b = i_imm;
            rv32i_pkg::u_imm: alu_b = u_imm;
            rv32i_pkg::b_imm: alu_b = b_imm;
            rv32i_pkg::j_imm: alu_b = j_imm;
            default:          alu_b = reg_b;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk)
    begin
        if (rst || br_taken || stall)
        begin
            ex_valid     <= 1'b0;
            ex_wen       <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_is_jalr   <= 1'b0;
        end
        else
        begin
            ex_valid     <= valid;
            ex_wen       <= wen;
            ex_is_branch <= is_branch;
            ex_is_jump   <= is_jump;
            ex_is_jalr   <= is_jalr;
            ex_pc        <= pc;
            ex_alu_a     <= alu_a;
            ex_alu_b     <= alu_b;
            ex_rs1       <= reg_a;
            ex_rs2       <= reg_b;
            ex_alu_op    <= alu_op;
            ex_cmp_op    <= cmp_op;
            ex_rd        <= dec_instr[11:7];
            // branch offset for the target adder
            ex_imm       <= b_imm;
        end
    end

    // the bubble clears execute, so the conflict is gone a cycle later
    stall_lasts_one_cycle: assert property (@(posedge clk) disable iff (rst)
        stall |=> !stall);

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
    input  rv32i_pkg::rv32i_reg src_a,
    input  rv32i_pkg::rv32i_reg src_b,
    input  logic                uses_rs1,
    input  logic                uses_rs2,
    input  rv32i_pkg::rv32i_reg ex_rd,
    input  logic                ex_wen,
    input  logic                ex_valid,
    output logic                bubble
);

    logic ex_writes;
    logic hit_a;
    logic hit_b;

    assign ex_writes = ex_valid && ex_wen;
    // x0 never carries a dependence
    assign hit_a = uses_rs1 && src_a != 5'd0 && src_a == ex_rd;
    assign hit_b = uses_rs2 && src_b != 5'd0 && src_b == ex_rd;

    assign bubble = ex_writes && (hit_a || hit_b);

endmodule

`default_nettype wire

// File: design/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom
(
    input  rv32i_pkg::rv32i_word     instr,
    output rv32i_pkg::alu_ops_t      alu_op,
    output rv32i_pkg::cmp_ops_t      cmp_op,
    output rv32i_pkg::alumux1_sel_t  alumux1_sel,
    output rv32i_pkg::alumux2_sel_t  alumux2_sel,
    output logic                     is_branch,
    output logic                     is_jump,
    output logic                     is_jalr,
    output logic                     wen,
    output logic                     valid,
    output logic                     uses_rs1,
    output logic                     uses_rs2
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       f7_ok;
    rv32i_pkg::alu_ops_t arith_op;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = funct7 == 7'b0100000;

    // shared funct3 decode for register and immediate forms
    always_comb
    begin
        f7_ok = funct7 == 7'b0000000;
        case (funct3)
            3'b000: arith_op = rv32i_pkg::alu_add;
            3'b001: arith_op = rv32i_pkg::alu_sll;
            3'b010: arith_op = rv32i_pkg::alu_slt;
            3'b011: arith_op = rv32i_pkg::alu_sltu;
            3'b100: arith_op = rv32i_pkg::alu_xor;
            3'b101: arith_op = alt ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110: arith_op = rv32i_pkg::alu_or;
            default: arith_op = rv32i_pkg::alu_and;
        endcase
        if (funct3 == 3'b101 || funct3 == 3'b000)
            f7_ok = f7_ok || alt;
    end

    always_comb
    begin
        alu_op      = rv32i_pkg::alu_add;
        cmp_op      = rv32i_pkg::cmp_ops_t'(funct3);
        alumux1_sel = rv32i_pkg::rs1_out;
        alumux2_sel = rv32i_pkg::i_imm;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        is_jalr     = 1'b0;
        wen         = 1'b0;
        valid       = 1'b0;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;

        case (instr[6:0])
            rv32i_pkg::op_lui:
            begin
                alu_op      = rv32i_pkg::alu_pass_b;
                alumux2_sel = rv32i_pkg::u_imm;
                wen         = 1'b1;
                valid       = 1'b1;
            end
            rv32i_pkg::op_auipc:
            begin
                alumux1_sel = rv32i_pkg::pc_out;
                alumux2_sel = rv32i_pkg::u_imm;
                wen         = 1'b1;
                valid       = 1'b1;
            end
            rv32i_pkg::op_jal:
            begin
                alumux1_sel = rv32i_pkg::pc_out;
                alumux2_sel = rv32i_pkg::j_imm;
                is_jump     = 1'b1;
                wen         = 1'b1;
                valid       = 1'b1;
            end
            rv32i_pkg::op_jalr:
            begin
                is_jump  = funct3 == 3'b000;
                is_jalr  = funct3 == 3'b000;
                wen      = funct3 == 3'b000;
                valid    = funct3 == 3'b000;
                uses_rs1 = funct3 == 3'b000;
            end
            rv32i_pkg::op_br:
            begin
                // funct3 010 and 011 are not branches
                valid     = funct3[2:1] != 2'b01;
                is_branch = valid;
                uses_rs1  = valid;
                uses_rs2  = valid;
            end
            rv32i_pkg::op_imm:
            begin
                alu_op   = arith_op;
                // only shifts constrain funct7 here
                valid    = (funct3[1:0] != 2'b01) || f7_ok;
                wen      = valid;
                uses_rs1 = valid;
            end
            rv32i_pkg::op_reg:
            begin
                alu_op      = (funct3 == 3'b000 && alt) ? rv32i_pkg::alu_sub : arith_op;
                alumux2_sel = rv32i_pkg::rs2_out;
                valid       = f7_ok;
                wen         = valid;
                uses_rs1    = valid;
                uses_rs2    = valid;
            end
            default:
            begin
                valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  rv32i_pkg::rv32i_word in,
    input  rv32i_pkg::rv32i_reg  src_a,
    input  rv32i_pkg::rv32i_reg  src_b,
    input  rv32i_pkg::rv32i_reg  dest,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);

    // x0 has no storage
    rv32i_pkg::rv32i_word data [1:31];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (load && dest != 5'd0)
        begin
            data[dest] <= in;
        end
    end

    // writeback in flight is visible to decode in the same cycle
    always_comb
    begin
        if (src_a == 5'd0)
            reg_a = '0;
        else if (load && dest == src_a)
            reg_a = in;
        else
            reg_a = data[src_a];

        if (src_b == 5'd0)
            reg_b = '0;
        else if (load && dest == src_b)
            reg_b = in;
        else
            reg_b = data[src_b];
    end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                br_taken,
    input  rv32i_pkg::rv32i_word br_target,
    output rv32i_pkg::rv32i_word pc
);

    // redirect wins over stall, stall wins over sequential fetch
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= rv32i_pkg::reset_pc;
        end
        else if (br_taken)
        begin
            pc <= br_target;
        end
        else if (!stall)
        begin
            pc <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: design/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] rv32i_word;
    typedef logic [4:0]      rv32i_reg;

    localparam rv32i_word reset_pc  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_ops_t;

    // values follow the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_ops_t;

    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        i_imm   = 3'd0,
        u_imm   = 3'd1,
        b_imm   = 3'd2,
        j_imm   = 3'd3,
        rs2_out = 3'd4
    } alumux2_sel_t;

endpackage

`default_nettype wire
